/* compile.f */
hdl/meco_pkg.sv
hdl/ebi_slave.sv
hdl/ram_arbiter.sv
hdl/config_ram.sv
hdl/command_engine.sv
hdl/pin_waveform.sv
hdl/mecobo_top.sv
sim/tb_clock.sv
sim/mecobo_assertions.sv
sim/mecobo_tb.sv

/* hdl/command_engine.sv */
// command_engine: scans the pin configuration blocks in RAM and loads each pin generator in turn
`timescale 1ns/1ns
module command_engine (
  input  logic                clk,
  input  logic                rst_n,
  output meco_pkg::ram_req_t  eng_req,
  input  logic                eng_gnt,
  input  meco_pkg::data_t     rdata,
  output meco_pkg::pin_load_t pin_load
);

  typedef enum logic [2:0] {
    IDLE,
    REQ_MODE,
    REQ_PERIOD,
    REQ_DUTY,
    LOAD
  } eng_state_e;

  eng_state_e state_q;
  eng_state_e state_nx;

  meco_pkg::pin_idx_t pin_q;
  meco_pkg::pin_cfg_t cfg_q;
  meco_pkg::addr_t    word_off;
  meco_pkg::addr_t    blk_addr;
  logic               in_req;

  // next state, a read state only advances once its grant shows up
  always_comb begin
    state_nx = state_q;
    case (state_q)
      IDLE:       state_nx = REQ_MODE;
      REQ_MODE:   if (eng_gnt) state_nx = REQ_PERIOD;
      REQ_PERIOD: if (eng_gnt) state_nx = REQ_DUTY;
      REQ_DUTY:   if (eng_gnt) state_nx = LOAD;
      LOAD:       state_nx = REQ_MODE;
      default:    state_nx = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      pin_q   <= '0;
    end else begin
      state_q <= state_nx;
      // wraps from the last pin back to pin 0
      if (state_q == LOAD) begin
        pin_q <= pin_q + 1'b1;
      end
    end
  end

  // the grant cycle carries the data, capture it there
  always_ff @(posedge clk) begin
    if (eng_gnt) begin
      case (state_q)
        REQ_MODE: begin
          // illegal mode words fall back to off
          if (rdata[meco_pkg::DATA_W-1:2] == '0) begin
            cfg_q.mode <= meco_pkg::wave_mode_e'(rdata[1:0]);
          end else begin
            cfg_q.mode <= meco_pkg::WAVE_OFF;
          end
        end
        REQ_PERIOD: cfg_q.period <= rdata;
        REQ_DUTY:   cfg_q.duty <= rdata;
        default:    ;
      endcase
    end
  end

  // which word of the current pin block is read
  always_comb begin
    case (state_q)
      REQ_PERIOD: word_off = meco_pkg::WORD_PERIOD;
      REQ_DUTY:   word_off = meco_pkg::WORD_DUTY;
      default:    word_off = meco_pkg::WORD_MODE;
    endcase
  end

  assign blk_addr = meco_pkg::PIN_BASE + meco_pkg::addr_t'(pin_q) * meco_pkg::PIN_STRIDE;

  assign in_req = (state_q == REQ_MODE) || (state_q == REQ_PERIOD) || (state_q == REQ_DUTY);

  // request is dropped in the grant cycle so each word is read once
  always_comb begin
    eng_req.req   = in_req & ~eng_gnt;
    eng_req.wr    = 1'b0;
    eng_req.addr  = blk_addr + word_off;
    eng_req.wdata = '0;
  end

  assign pin_load = '{load: (state_q == LOAD), pin: pin_q, cfg: cfg_q};

endmodule

/* hdl/config_ram.sv */
// config_ram: single-port synchronous configuration RAM with read-first behavior
`timescale 1ns/1ns
module config_ram (
  input  logic               clk,
  input  meco_pkg::ram_req_t ram_req,
  output meco_pkg::data_t    rdata
);

  localparam int DEPTH = 2 ** meco_pkg::ADDR_W;

  meco_pkg::data_t mem [DEPTH];

  // read-first, a write returns the old word
  // rdata holds its value between accesses
  always_ff @(posedge clk) begin
    if (ram_req.req) begin
      if (ram_req.wr) begin
        mem[ram_req.addr] <= ram_req.wdata;
      end
      rdata <= mem[ram_req.addr];
    end
  end

endmodule

/* hdl/ebi_slave.sv */
// ebi_slave: turns asynchronous EBI strobes into single RAM requests and returns read data
`timescale 1ns/1ns
module ebi_slave (
  input  logic              clk,
  input  logic              rst_n,
  input  meco_pkg::addr_t   ebi_addr,
  input  meco_pkg::data_t   ebi_wdata,
  input  logic              ebi_cs,
  input  logic              ebi_wr,
  input  logic              ebi_rd,
  output meco_pkg::ram_req_t host_req,
  input  logic              host_gnt,
  input  meco_pkg::data_t   rdata,
  output meco_pkg::data_t   ebi_rdata,
  output logic              fpga_ready
);

  // bits 0 and 1 synchronize, bit 2 is the history for edge detection
  logic [2:0] wr_sync;
  logic [2:0] rd_sync;
  logic       wr_rise;
  logic       rd_rise;

  logic            req_q;
  logic            wr_q;
  meco_pkg::addr_t addr_q;
  meco_pkg::data_t wdata_q;

  logic ready_q;
  logic capture;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_sync <= '0;
      rd_sync <= '0;
    end else begin
      wr_sync <= {wr_sync[1:0], ebi_cs & ebi_wr};
      rd_sync <= {rd_sync[1:0], ebi_cs & ebi_rd};
    end
  end

  // one pulse per host access
  assign wr_rise = wr_sync[1] & ~wr_sync[2];
  assign rd_rise = rd_sync[1] & ~rd_sync[2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
    end else begin
      req_q <= wr_rise | rd_rise;
    end
  end

  // address and data are stable by now, the host holds them through the access
  always_ff @(posedge clk) begin
    if (wr_rise | rd_rise) begin
      wr_q    <= wr_rise;
      addr_q  <= ebi_addr;
      wdata_q <= ebi_wdata;
    end
  end

  assign host_req = '{req: req_q, wr: wr_q, addr: addr_q, wdata: wdata_q};

  // the registered grant lines up with valid ram data
  assign capture = host_gnt & ~wr_q;

  always_ff @(posedge clk) begin
    if (capture) begin
      ebi_rdata <= rdata;
    end
  end

  // ready stays up until the synchronized read strobe drops
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
    end else if (!rd_sync[1]) begin
      ready_q <= 1'b0;
    end else if (capture) begin
      ready_q <= 1'b1;
    end
  end

  // gated by the raw strobes so ready never outlives the read
  assign fpga_ready = ready_q & ebi_cs & ebi_rd;

endmodule

/* hdl/meco_pkg.sv */
// meco_pkg: shared sizes, address map, waveform encoding and bus structs for the pin controller
package meco_pkg;

  // bus and ram geometry
  localparam int DATA_W = 16;
  localparam int ADDR_W = 8;

  // pin generator count and index width
  localparam int NUM_PINS = 8;
  localparam int PIN_W = $clog2(NUM_PINS);

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [PIN_W-1:0] pin_idx_t;

  // configuration blocks start here, everything below is host scratch
  localparam addr_t PIN_BASE = 8'h20;
  // words reserved per pin block
  localparam addr_t PIN_STRIDE = 8'd4;

  // word offsets inside one pin block, word 3 is reserved
  localparam addr_t WORD_MODE = 8'd0;
  localparam addr_t WORD_PERIOD = 8'd1;
  localparam addr_t WORD_DUTY = 8'd2;

  // pin waveform shapes
  typedef enum logic [1:0] {
    WAVE_OFF    = 2'd0,
    WAVE_SQUARE = 2'd1,
    WAVE_PWM    = 2'd2,
    WAVE_HIGH   = 2'd3
  } wave_mode_e;

  // one access request toward the shared ram port
  typedef struct packed {
    logic  req;
    logic  wr;
    addr_t addr;
    data_t wdata;
  } ram_req_t;

  // settings of one pin generator
  typedef struct packed {
    wave_mode_e mode;
    data_t      period;
    data_t      duty;
  } pin_cfg_t;

  // broadcast from the command engine to all pin generators
  typedef struct packed {
    logic     load;
    pin_idx_t pin;
    pin_cfg_t cfg;
  } pin_load_t;

endpackage

/* hdl/mecobo_top.sv */
// mecobo_top: EBI host port, shared config RAM, command engine and eight pin waveform generators
`timescale 1ns/1ns
module mecobo_top (
  input  logic                          clk,
  input  logic                          rst_n,
  inout  wire  [meco_pkg::DATA_W-1:0]   ebi_data,
  input  logic [meco_pkg::ADDR_W-1:0]   ebi_addr,
  input  logic                          ebi_cs,
  input  logic                          ebi_wr,
  input  logic                          ebi_rd,
  output logic                          fpga_ready,
  output logic [meco_pkg::NUM_PINS-1:0] pin_out
);

  meco_pkg::ram_req_t  host_req;
  meco_pkg::ram_req_t  eng_req;
  meco_pkg::ram_req_t  ram_req;
  logic                host_gnt;
  logic                eng_gnt;
  meco_pkg::data_t     rdata;
  meco_pkg::data_t     ebi_rdata;
  meco_pkg::pin_load_t pin_load;
  logic                data_oe;

  // data bus driven only while the host reads and the word is valid
  assign data_oe  = fpga_ready;
  assign ebi_data = data_oe ? ebi_rdata : 'z;

  ebi_slave ebi_slave_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .ebi_addr   (ebi_addr),
    .ebi_wdata  (ebi_data),
    .ebi_cs     (ebi_cs),
    .ebi_wr     (ebi_wr),
    .ebi_rd     (ebi_rd),
    .host_req   (host_req),
    .host_gnt   (host_gnt),
    .rdata      (rdata),
    .ebi_rdata  (ebi_rdata),
    .fpga_ready (fpga_ready)
  );

  ram_arbiter ram_arbiter_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .host_req (host_req),
    .eng_req  (eng_req),
    .host_gnt (host_gnt),
    .eng_gnt  (eng_gnt),
    .ram_req  (ram_req)
  );

  config_ram config_ram_i (
    .clk     (clk),
    .ram_req (ram_req),
    .rdata   (rdata)
  );

  command_engine command_engine_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .eng_req  (eng_req),
    .eng_gnt  (eng_gnt),
    .rdata    (rdata),
    .pin_load (pin_load)
  );

  // every generator sees the same load bus and picks its own index
  for (genvar i = 0; i < meco_pkg::NUM_PINS; i++) begin : g_pin
    pin_waveform #(
      .PIN_INDEX (i)
    ) pin_waveform_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .pin_load (pin_load),
      .pin      (pin_out[i])
    );
  end

endmodule

/* hdl/pin_waveform.sv */
// pin_waveform: per-pin tick counter that shapes one output pin from its loaded settings
`timescale 1ns/1ns
module pin_waveform #(
  parameter int PIN_INDEX = 0
) (
  input  logic                clk,
  input  logic                rst_n,
  input  meco_pkg::pin_load_t pin_load,
  output logic                pin
);

  logic               hit;
  meco_pkg::pin_cfg_t cfg_q;
  meco_pkg::pin_cfg_t cfg_nx;
  meco_pkg::data_t    tick_q;
  logic               wrap;
  logic               pin_nx;

  // only the load aimed at this pin counts
  assign hit = pin_load.load && (pin_load.pin == meco_pkg::pin_idx_t'(PIN_INDEX));

  // a new setting already shapes the very next output value
  assign cfg_nx = hit ? pin_load.cfg : cfg_q;

  // also wraps when a shorter period leaves the tick past its end
  assign wrap = (cfg_nx.period == '0) || (tick_q >= cfg_nx.period - meco_pkg::data_t'(1));

  always_comb begin
    case (cfg_nx.mode)
      meco_pkg::WAVE_SQUARE: pin_nx = tick_q < (cfg_nx.period >> 1);
      // duty at or past the period keeps the pin high
      meco_pkg::WAVE_PWM:    pin_nx = tick_q < cfg_nx.duty;
      meco_pkg::WAVE_HIGH:   pin_nx = 1'b1;
      default:               pin_nx = 1'b0;
    endcase
    // zero period means a dead pin whatever the mode
    if (cfg_nx.period == '0) begin
      pin_nx = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q  <= '0;
      tick_q <= '0;
      pin    <= 1'b0;
    end else begin
      cfg_q  <= cfg_nx;
      tick_q <= wrap ? '0 : tick_q + 1'b1;
      pin    <= pin_nx;
    end
  end

endmodule

/* hdl/ram_arbiter.sv */
// ram_arbiter: fixed-priority sharing of the single RAM port, host first, command engine second
`timescale 1ns/1ns
module ram_arbiter (
  input  logic               clk,
  input  logic               rst_n,
  input  meco_pkg::ram_req_t host_req,
  input  meco_pkg::ram_req_t eng_req,
  output logic               host_gnt,
  output logic               eng_gnt,
  output meco_pkg::ram_req_t ram_req
);

  logic host_win;
  logic eng_win;

  // host always wins, the engine only gets idle cycles
  assign host_win = host_req.req;
  assign eng_win  = eng_req.req & ~host_req.req;

  // the winner reaches the ram in the same cycle
  // with no host request the engine request passes, req may be low
  always_comb begin
    if (host_win) begin
      ram_req = host_req;
    end else begin
      ram_req = eng_req;
    end
  end

  // grants are delayed one cycle
  // a high grant tells the requester its read data is on rdata now
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      host_gnt <= 1'b0;
      eng_gnt  <= 1'b0;
    end else begin
      host_gnt <= host_win;
      eng_gnt  <= eng_win;
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the pin controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module mecobo_tb \
  --Mdir obj_dir -o mecobo_sim
./obj_dir/mecobo_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* sim/mecobo_assertions.sv */
// mecobo_assertions: arbitration, EBI read and load pulse checks bound into the top level
`timescale 1ns/1ns
module mecobo_assertions (
  input logic                clk,
  input logic                rst_n,
  input logic                host_gnt,
  input logic                eng_gnt,
  input logic                fpga_ready,
  input logic                data_oe,
  input meco_pkg::data_t     ebi_rdata,
  input meco_pkg::pin_load_t pin_load
);

  // one ram port so at most one owner per cycle
  grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    !(host_gnt && eng_gnt))
    else $error("host and engine granted in the same cycle");

  // ready only comes up once the host grant has delivered the word
  ready_after_grant: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(fpga_ready) |-> $past(host_gnt))
    else $error("fpga_ready rose without a preceding host grant");

  // load is a strobe and never a level
  load_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    pin_load.load |=> !pin_load.load)
    else $error("pin load held longer than one cycle");

  // driven read data holds still for the whole read
  oe_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (data_oe && $past(data_oe)) |-> $stable(ebi_rdata))
    else $error("ebi_data changed while driven to the host");

endmodule

bind mecobo_top mecobo_assertions mecobo_assertions_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .host_gnt   (host_gnt),
  .eng_gnt    (eng_gnt),
  .fpga_ready (fpga_ready),
  .data_oe    (data_oe),
  .ebi_rdata  (ebi_rdata),
  .pin_load   (pin_load)
);

/* sim/mecobo_tb.sv */
// mecobo_tb: table-driven EBI programming and pin waveform measurement for the pin controller
`timescale 1ns/1ns
module mecobo_tb;

  localparam int DRIVE_DELAY = 2;
  localparam int WR_HOLD = 6;
  localparam int GAP = 4;
  localparam int READY_LIMIT = 16;
  localparam int FALL_LIMIT = 3;
  localparam int SETTLE = 200;
  localparam int ZERO_WINDOW = 40;
  localparam int N_SCRATCH = 6;
  localparam int NUM_ROWS = 11;
  localparam int NUM_PHASES = 2;
  localparam int ACCESS_CYCLES = 16;
  localparam int RESET_CYCLES = 10;

  // one pin setting plus the high count expected per window of 4 periods
  typedef struct packed {
    int              phase;
    int              pin;
    meco_pkg::data_t mode;
    meco_pkg::data_t period;
    meco_pkg::data_t duty;
    int              expected;
  } cfg_row_t;

  logic                            clk;
  logic                            rst_n;
  wire  [meco_pkg::DATA_W-1:0]     ebi_data;
  logic [meco_pkg::ADDR_W-1:0]     ebi_addr;
  logic                            ebi_cs;
  logic                            ebi_wr;
  logic                            ebi_rd;
  logic                            fpga_ready;
  logic [meco_pkg::NUM_PINS-1:0]   pin_out;
  logic                            tb_oe;
  meco_pkg::data_t                 tb_wdata;

  cfg_row_t    cfg_rows [NUM_ROWS];
  int          cur_period [meco_pkg::NUM_PINS];
  int          exp_count [meco_pkg::NUM_PINS];
  logic [15:0] lfsr_state;
  logic        measure_done;
  int          cycle_limit;
  int          cycle_count;

  // host side of the shared data bus
  assign ebi_data = tb_oe ? tb_wdata : 'z;

  tb_clock tb_clock_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mecobo_top mecobo_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .ebi_data   (ebi_data),
    .ebi_addr   (ebi_addr),
    .ebi_cs     (ebi_cs),
    .ebi_wr     (ebi_wr),
    .ebi_rd     (ebi_rd),
    .fpga_ready (fpga_ready),
    .pin_out    (pin_out)
  );

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input meco_pkg::data_t got,
                            input meco_pkg::data_t expected);
    if (got !== expected) begin
      report_failure($sformatf("FAIL at %0t ns: %s is %h, expected %h",
                               $time, name, got, expected));
    end
  endtask

  task automatic check_pin(input int pin, input int got, input int expected);
    if (got != expected) begin
      report_failure($sformatf("FAIL at %0t ns: high count of pin_out[%0d] is %0d, expected %0d",
                               $time, pin, got, expected));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      report_failure($sformatf("FAIL at %0t ns: %s is %b, expected %b",
                               $time, name, got, expected));
    end
  endtask

  // galois lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  // one lfsr step per bit taken
  task automatic random_bits(input int width, output logic [15:0] value);
    value = '0;
    for (int i = 0; i < width; i++) begin
      value = {value[14:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic meco_pkg::addr_t cfg_addr(input int pin, input int word);
    return meco_pkg::addr_t'(int'(meco_pkg::PIN_BASE) + pin * int'(meco_pkg::PIN_STRIDE) + word);
  endfunction

  // four full periods, a dead pin gets a fixed window
  function automatic int window_len(input int period);
    return (period == 0) ? ZERO_WINDOW : 4 * period;
  endfunction

  task automatic ebi_write(input meco_pkg::addr_t addr, input meco_pkg::data_t data);
    @(posedge clk);
    #DRIVE_DELAY;
    ebi_addr = addr;
    tb_wdata = data;
    tb_oe    = 1'b1;
    ebi_cs   = 1'b1;
    ebi_wr   = 1'b1;
    // the ram word changes 4 clocks in so this holds with margin
    repeat (WR_HOLD) @(posedge clk);
    #DRIVE_DELAY;
    ebi_cs = 1'b0;
    ebi_wr = 1'b0;
    tb_oe  = 1'b0;
    repeat (GAP) @(posedge clk);
  endtask

  task automatic ebi_read(input meco_pkg::addr_t addr, output meco_pkg::data_t data);
    int waited;
    @(posedge clk);
    #DRIVE_DELAY;
    ebi_addr = addr;
    ebi_cs   = 1'b1;
    ebi_rd   = 1'b1;
    waited   = 0;
    @(negedge clk);
    while (!fpga_ready) begin
      waited++;
      if (waited > READY_LIMIT) begin
        report_failure("fpga_ready never rose during a host read");
      end
      @(negedge clk);
    end
    data = ebi_data;
    @(posedge clk);
    #DRIVE_DELAY;
    ebi_cs = 1'b0;
    ebi_rd = 1'b0;
    waited = 0;
    @(negedge clk);
    while (fpga_ready) begin
      waited++;
      if (waited > FALL_LIMIT) begin
        report_failure("fpga_ready stayed high after the host ended its read");
      end
      @(negedge clk);
    end
    repeat (GAP) @(posedge clk);
  endtask

  // mode words 0 off 1 square 2 pwm 3 high, 7 is illegal
  task automatic fill_rows();
    cfg_rows[0]  = '{0, 0, 16'h0001, 16'd10, 16'd0,  20};
    cfg_rows[1]  = '{0, 1, 16'h0001, 16'd7,  16'd0,  12};
    cfg_rows[2]  = '{0, 2, 16'h0002, 16'd12, 16'd5,  20};
    cfg_rows[3]  = '{0, 3, 16'h0002, 16'd9,  16'd0,  0};
    cfg_rows[4]  = '{0, 4, 16'h0002, 16'd6,  16'd9,  24};
    cfg_rows[5]  = '{0, 5, 16'h0000, 16'd8,  16'd4,  0};
    cfg_rows[6]  = '{0, 6, 16'h0007, 16'd10, 16'd3,  0};
    cfg_rows[7]  = '{0, 7, 16'h0003, 16'd5,  16'd0,  20};
    // second pass turns square to off and checks edge cases
    cfg_rows[8]  = '{1, 1, 16'h0000, 16'd7,  16'd0,  0};
    cfg_rows[9]  = '{1, 0, 16'h0001, 16'd0,  16'd0,  0};
    cfg_rows[10] = '{1, 2, 16'h0002, 16'd12, 16'd12, 48};
  endtask

  // windows plus settle plus host accesses, doubled
  function automatic int timeout_cycles();
    int total;
    int accesses;
    int period_now [meco_pkg::NUM_PINS];
    total    = RESET_CYCLES;
    accesses = 2 * N_SCRATCH;
    foreach (period_now[p]) begin
      period_now[p] = 0;
    end
    for (int ph = 0; ph < NUM_PHASES; ph++) begin
      foreach (cfg_rows[r]) begin
        if (cfg_rows[r].phase == ph) begin
          period_now[cfg_rows[r].pin] = int'(cfg_rows[r].period);
          accesses += 6;
        end
      end
      total += SETTLE;
      foreach (period_now[p]) begin
        total += window_len(period_now[p]);
      end
    end
    total += accesses * ACCESS_CYCLES;
    return 2 * total;
  endfunction

  task automatic check_reset_state();
    check_flag("fpga_ready", fpga_ready, 1'b0);
    check_flag("ebi_data output enable", mecobo_top_i.data_oe, 1'b0);
    for (int p = 0; p < meco_pkg::NUM_PINS; p++) begin
      check_flag($sformatf("pin_out[%0d]", p), pin_out[p], 1'b0);
    end
  endtask

  // all writes first so each word must survive the others
  task automatic scratch_readback();
    logic [15:0]     a;
    logic [15:0]     d;
    meco_pkg::data_t got;
    meco_pkg::data_t model [32];
    logic [31:0]     written;
    written = '0;
    for (int i = 0; i < N_SCRATCH; i++) begin
      random_bits(5, a);
      random_bits(16, d);
      ebi_write(a[7:0], d);
      model[a[4:0]]   = d;
      written[a[4:0]] = 1'b1;
    end
    for (int s = 0; s < 32; s++) begin
      if (written[s]) begin
        ebi_read(meco_pkg::addr_t'(s), got);
        check_word($sformatf("scratch word %0d", s), got, model[s]);
      end
    end
  endtask

  task automatic apply_phase(input int ph);
    meco_pkg::data_t words [3];
    meco_pkg::data_t got;
    int              pin;
    foreach (cfg_rows[r]) begin
      if (cfg_rows[r].phase == ph) begin
        pin   = cfg_rows[r].pin;
        words = '{cfg_rows[r].mode, cfg_rows[r].period, cfg_rows[r].duty};
        for (int w = 0; w < 3; w++) begin
          ebi_write(cfg_addr(pin, w), words[w]);
        end
        for (int w = 0; w < 3; w++) begin
          ebi_read(cfg_addr(pin, w), got);
          check_word($sformatf("config word %0d of pin %0d", w, pin), got, words[w]);
        end
        cur_period[pin] = int'(cfg_rows[r].period);
        exp_count[pin]  = cfg_rows[r].expected;
      end
    end
  endtask

  // pins one after another over whole periods
  task automatic measure_pins();
    int cnt;
    for (int p = 0; p < meco_pkg::NUM_PINS; p++) begin
      cnt = 0;
      repeat (window_len(cur_period[p])) begin
        @(negedge clk);
        if (pin_out[p]) begin
          cnt++;
        end
      end
      check_pin(p, cnt, exp_count[p]);
    end
    measure_done = 1'b1;
  endtask

  // scratch traffic that keeps stealing ram cycles from the engine
  task automatic host_traffic();
    logic [15:0]     a;
    logic [15:0]     d;
    meco_pkg::data_t got;
    while (!measure_done) begin
      random_bits(5, a);
      random_bits(16, d);
      ebi_write(a[7:0], d);
      ebi_read(a[7:0], got);
      check_word($sformatf("scratch word %0d under load", a[4:0]), got, d);
    end
  endtask

  initial begin
    ebi_addr     = '0;
    ebi_cs       = 1'b0;
    ebi_wr       = 1'b0;
    ebi_rd       = 1'b0;
    tb_oe        = 1'b0;
    tb_wdata     = '0;
    measure_done = 1'b0;
    lfsr_state   = 16'd95;
    fill_rows();
    cycle_limit = timeout_cycles();
    @(posedge rst_n);
    @(negedge clk);
    check_reset_state();
    scratch_readback();
    for (int ph = 0; ph < NUM_PHASES; ph++) begin
      apply_phase(ph);
      // a full engine scan fits easily in the settle time
      repeat (SETTLE) @(posedge clk);
      measure_done = 1'b0;
      fork
        measure_pins();
        host_traffic();
      join
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

  // watchdog
  initial begin
    cycle_count = 0;
    @(posedge rst_n);
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        report_failure($sformatf("timeout after %0d cycles with the tests unfinished",
                                 cycle_count));
      end
    end
  end

endmodule

/* sim/tb_clock.sv */
// tb_clock: free-running 40 ns testbench clock and a reset held low for three cycles
`timescale 1ns/1ns
module tb_clock (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 20;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // release lands just after an edge like every other driven input
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
  end

endmodule
